/* store_buffer.f */
store_buf_pkg.sv
spec_store_queue.sv
commit_store_queue.sv
sb_lookup_merge.sv
store_buffer_top.sv
tb_mem_sink.sv
tb_store_buffer.sv

/* run_sim.sh */
#!/bin/sh
# compile the store buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_store_buffer -Mdir obj_dir -f store_buffer.f

# the testbench reports its own result, so the exit status of the run is not used
out=$(./obj_dir/Vtb_store_buffer) || true
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

/* tb_store_buffer.sv */
// ----------------------------------------------------------------------
// testbench of the store buffer
// clock, reset and a stimulus table applied in a loop
// reference model of the speculative list and the memory order
// flag, hazard, credit and memory order checks with a watchdog
// ----------------------------------------------------------------------
module tb_store_buffer
  import store_buf_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam time CLK_PERIOD  = 100;
  localparam int  TABLE_LEN   = 30;
  localparam int  DRAIN_ROWS  = 16;
  localparam int  CYCLE_BOUND = 16;

  typedef enum logic [2:0] {OP_IDLE, OP_PUSH, OP_COMMIT, OP_FLUSH, OP_STALL, OP_LOOKUP} op_e;

  // fixed rows take address and data as given, others randomize data and page number
  typedef struct packed {
    op_e         op;
    logic        fixed;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  delay;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic         valid;
  store_entry_t store;
  logic         ready;
  logic         commit;
  logic         commit_ready;
  logic         flush;
  logic         stall;
  logic [11:0]  page_offset;
  logic         offset_match;
  logic         no_st_pending;
  logic         empty;
  mem_store_t   mem_req;
  logic         mem_credit;
  logic [3:0]   credit_delay;
  int           outstanding;
  int           seed = 32'hda95_4576;
  int           n_checks;
  int           n_errors;
  row_t         rows [$];
  // the model holds uncommitted stores and every store committed so far
  store_entry_t spec_q [$];
  store_entry_t exp_mem_q [$];

  store_buffer_top UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .valid_i         (valid),
    .store_i         (store),
    .ready_o         (ready),
    .commit_i        (commit),
    .commit_ready_o  (commit_ready),
    .flush_i         (flush),
    .stall_i         (stall),
    .page_offset_i   (page_offset),
    .offset_match_o  (offset_match),
    .no_st_pending_o (no_st_pending),
    .empty_o         (empty),
    .mem_req_o       (mem_req),
    .mem_credit_i    (mem_credit)
  );

  tb_mem_sink i_sink (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (mem_req),
    .delay_i       (credit_delay),
    .credit_o      (mem_credit),
    .outstanding_o (outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // the slowest credit delay bounds how long any row or drain cycle may take
  initial begin
    #(CLK_PERIOD * (TABLE_LEN + DRAIN_ROWS) * CYCLE_BOUND);
    $display("watchdog expired, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic add_row(input op_e op, input logic fixed, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] delay);
    row_t r;
    r.op    = op;
    r.fixed = fixed;
    r.addr  = addr;
    r.data  = data;
    r.delay = delay;
    rows.push_back(r);
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // committed stores that the memory has not yet recorded
  function automatic int pending_count();
    return exp_mem_q.size() - i_sink.log_q.size();
  endfunction

  // any buffered store or the incoming one that hits the same word in the page
  function automatic logic model_match(input logic [11:0] offset, input logic push,
                                       input logic [31:0] addr);
    logic hit;
    hit = push && (addr[11:2] == offset[11:2]);
    foreach (spec_q[i]) begin
      if (spec_q[i].addr[11:2] == offset[11:2]) begin
        hit = 1'b1;
      end
    end
    for (int i = i_sink.log_q.size(); i < exp_mem_q.size(); i++) begin
      if (exp_mem_q[i].addr[11:2] == offset[11:2]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_flags();
    check_value("ready_o", ready, (spec_q.size() < SPEC_DEPTH) || commit);
    check_value("commit_ready_o", commit_ready, pending_count() < COMMIT_DEPTH);
    check_value("no_st_pending_o", no_st_pending, pending_count() == 0);
    check_value("empty_o", empty, (pending_count() == 0) && (spec_q.size() == 0));
    check_value("offset_match_o", offset_match, model_match(page_offset, valid, store.addr));
    check_value("stores in flight within credits", outstanding <= MEM_CREDITS, 1'b1);
    if (stall) begin
      check_value("request while stalled", mem_req.valid, 1'b0);
    end
  endtask

  task automatic drive_idle();
    valid  = 1'b0;
    commit = 1'b0;
    flush  = 1'b0;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    drive_idle();
    #1;
    check_flags();
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0]  rnd_addr;
    logic [31:0]  rnd_data;
    store_entry_t st;
    @(negedge clk);
    drive_idle();
    credit_delay = r.delay;
    // a commit has to wait until the memory has drained a slot
    while ((r.op == OP_COMMIT) && (pending_count() >= COMMIT_DEPTH)) begin
      #1;
      check_flags();
      @(negedge clk);
    end
    rnd_addr = $random(seed);
    rnd_data = $random(seed);
    st.addr = r.fixed ? r.addr : {rnd_addr[31:12], r.addr[11:0]};
    st.data = r.fixed ? r.data : rnd_data;
    // aligned addresses store a word, all others a single byte
    if (st.addr[1:0] == 2'b00) begin
      st.be   = '1;
      st.size = 2'b10;
    end else begin
      st.be   = BE_WIDTH'(1) << st.addr[1:0];
      st.size = 2'b00;
    end
    // a push keeps the offset of the last lookup, so the incoming store may hit or miss
    case (r.op)
      OP_PUSH: begin
        valid = 1'b1;
        store = st;
      end
      OP_COMMIT: commit = 1'b1;
      OP_FLUSH:  flush = 1'b1;
      OP_STALL:  stall = r.data[0];
      OP_LOOKUP: page_offset = r.addr[11:0];
      default: ;
    endcase
    #1;
    check_flags();
    // the model follows the DUT state after the coming rising edge
    case (r.op)
      OP_PUSH:   spec_q.push_back(st);
      OP_COMMIT: exp_mem_q.push_back(spec_q.pop_front());
      OP_FLUSH:  spec_q.delete();
      default: ;
    endcase
  endtask

  task automatic check_memory_order();
    check_value("stores seen by memory", i_sink.log_q.size(), exp_mem_q.size());
    foreach (exp_mem_q[i]) begin
      if (i < i_sink.log_q.size()) begin
        check_value($sformatf("memory store %0d", i), i_sink.log_q[i], exp_mem_q[i]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------------------

  task automatic load_table();
    add_row(OP_PUSH,   1'b1, 32'h0000_1100, 32'hdead_beef, 4'd1);
    add_row(OP_PUSH,   1'b0, 32'h204, 32'h0, 4'd1);
    add_row(OP_LOOKUP, 1'b0, 32'h104, 32'h0, 4'd1);
    add_row(OP_LOOKUP, 1'b0, 32'h102, 32'h0, 4'd1);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd1);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd1);
    add_row(OP_IDLE,   1'b0, 32'h0,   32'h0, 4'd1);
    add_row(OP_PUSH,   1'b0, 32'h301, 32'h0, 4'd1);
    add_row(OP_LOOKUP, 1'b0, 32'h300, 32'h0, 4'd1);
    add_row(OP_FLUSH,  1'b0, 32'h0,   32'h0, 4'd1);
    add_row(OP_LOOKUP, 1'b0, 32'h300, 32'h0, 4'd1);
    // slow credits and a stall back up the commit queue until it is full
    add_row(OP_STALL,  1'b0, 32'h0,   32'h1, 4'd6);
    add_row(OP_PUSH,   1'b0, 32'h440, 32'h0, 4'd6);
    add_row(OP_PUSH,   1'b0, 32'h446, 32'h0, 4'd6);
    add_row(OP_PUSH,   1'b0, 32'h448, 32'h0, 4'd6);
    add_row(OP_PUSH,   1'b0, 32'h44c, 32'h0, 4'd6);
    // the speculative queue is full here and no commit frees a slot
    add_row(OP_LOOKUP, 1'b0, 32'h446, 32'h0, 4'd6);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd6);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd6);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd6);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd6);
    add_row(OP_LOOKUP, 1'b0, 32'h44a, 32'h0, 4'd6);
    add_row(OP_PUSH,   1'b0, 32'h500, 32'h0, 4'd6);
    add_row(OP_STALL,  1'b0, 32'h0,   32'h0, 4'd6);
    add_row(OP_COMMIT, 1'b0, 32'h0,   32'h0, 4'd6);
    // only the incoming store hits this word
    add_row(OP_LOOKUP, 1'b0, 32'h604, 32'h0, 4'd3);
    add_row(OP_PUSH,   1'b0, 32'h604, 32'h0, 4'd3);
    add_row(OP_FLUSH,  1'b0, 32'h0,   32'h0, 4'd3);
    add_row(OP_LOOKUP, 1'b0, 32'h604, 32'h0, 4'd3);
    add_row(OP_IDLE,   1'b0, 32'h0,   32'h0, 4'd3);
  endtask

  initial begin
    rst_n        = 1'b0;
    valid        = 1'b0;
    store        = '0;
    commit       = 1'b0;
    flush        = 1'b0;
    stall        = 1'b0;
    page_offset  = '0;
    credit_delay = 4'd1;
    n_checks     = 0;
    n_errors     = 0;
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("request after reset", mem_req.valid, 1'b0);
    check_flags();
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    // the commit queue drains at the pace of the returned credits
    while (!no_st_pending) begin
      idle_cycle();
    end
    idle_cycle();
    check_memory_order();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb_mem_sink.sv */
// ----------------------------------------------------------------------
// testbench memory model of the store buffer
// records every issued store in arrival order
// returns one credit per store after a programmable delay
// ----------------------------------------------------------------------
module tb_mem_sink
  import store_buf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mem_store_t req_i,
  input  logic [3:0] delay_i,
  output logic       credit_o,
  output int         outstanding_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // stores as they arrived, read by the testbench top at the end of the run
  store_entry_t log_q [$];
  // cycle numbers at which the pending credits fall due, oldest first
  int unsigned  due_q [$];
  int unsigned  cycle;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle = 0;
      due_q.delete();
      credit_o      <= 1'b0;
      outstanding_o <= 0;
    end else begin
      cycle = cycle + 1;
      // there is no grant, so a valid request is absorbed at this edge
      if (req_i.valid) begin
        log_q.push_back(req_i.store);
        due_q.push_back(cycle + delay_i);
      end
      // a credit that is high now is taken by the DUT at this same edge
      outstanding_o <= outstanding_o + int'(req_i.valid) - int'(credit_o);
      // at most one credit per cycle, even when several fall due together
      if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
        credit_o <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        credit_o <= 1'b0;
      end
    end
  end

endmodule

/* store_buffer_top.sv */
// ----------------------------------------------------------------------
// store buffer top level
// speculative queue and commit queue side by side
// lookup and status block fed by the views of both queues
// ----------------------------------------------------------------------
module store_buffer_top
  import store_buf_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         valid_i,
  input  store_entry_t store_i,
  output logic         ready_o,
  input  logic         commit_i,
  output logic         commit_ready_o,
  input  logic         flush_i,
  input  logic         stall_i,
  input  logic [11:0]  page_offset_i,
  output logic         offset_match_o,
  output logic         no_st_pending_o,
  output logic         empty_o,
  output mem_store_t   mem_req_o,
  input  logic         mem_credit_i
);

  store_entry_t commit_entry;
  spec_view_t   spec_view;
  commit_view_t commit_view;

  // stores wait here until the core commits or flushes them
  spec_store_queue i_spec_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (valid_i),
    .store_i        (store_i),
    .commit_i       (commit_i),
    .flush_i        (flush_i),
    .ready_o        (ready_o),
    .commit_entry_o (commit_entry),
    .view_o         (spec_view)
  );

  // committed stores are final and drain to memory in order
  commit_store_queue i_commit_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_i       (commit_i),
    .commit_entry_i (commit_entry),
    .stall_i        (stall_i),
    .mem_credit_i   (mem_credit_i),
    .commit_ready_o (commit_ready_o),
    .mem_req_o      (mem_req_o),
    .view_o         (commit_view)
  );

  sb_lookup_merge i_lookup (
    .page_offset_i   (page_offset_i),
    .push_i          (valid_i),
    .store_addr_i    (store_i.addr),
    .spec_view_i     (spec_view),
    .commit_view_i   (commit_view),
    .offset_match_o  (offset_match_o),
    .no_st_pending_o (no_st_pending_o),
    .empty_o         (empty_o)
  );

endmodule

/* sb_lookup_merge.sv */
// ----------------------------------------------------------------------
// hazard check and status flags of the store buffer
// matches a load page offset against both queue views and the incoming store
// ----------------------------------------------------------------------
module sb_lookup_merge
  import store_buf_pkg::*;
(
  input  logic [11:0]            page_offset_i,
  input  logic                   push_i,
  input  logic [PADDR_WIDTH-1:0] store_addr_i,
  input  spec_view_t             spec_view_i,
  input  commit_view_t           commit_view_i,
  output logic                   offset_match_o,
  output logic                   no_st_pending_o,
  output logic                   empty_o
);

  logic [OFFSET_WIDTH-1:0] load_word;

  // byte bits are ignored so any overlap within a word counts as a hit
  assign load_word = page_offset_i[OFFSET_MSB:OFFSET_LSB];

  always_comb begin
    offset_match_o = 1'b0;
    for (int i = 0; i < COMMIT_DEPTH; i++) begin
      if (commit_view_i.valid[i] && (commit_view_i.offset[i] == load_word)) begin
        offset_match_o = 1'b1;
      end
    end
    for (int i = 0; i < SPEC_DEPTH; i++) begin
      if (spec_view_i.valid[i] && (spec_view_i.offset[i] == load_word)) begin
        offset_match_o = 1'b1;
      end
    end
    // the store entering the queue this cycle is not yet in any view
    if (push_i && (store_addr_i[OFFSET_MSB:OFFSET_LSB] == load_word)) begin
      offset_match_o = 1'b1;
    end
  end

  // nothing is pending once every committed store has left for memory
  assign no_st_pending_o = (commit_view_i.valid == '0);
  assign empty_o         = no_st_pending_o && (spec_view_i.valid == '0);

endmodule

/* commit_store_queue.sv */
// ----------------------------------------------------------------------
// commit store queue
// circular buffer filled by commits from the speculative queue
// drains to memory in order under a credit counter
// ----------------------------------------------------------------------
module commit_store_queue
  import store_buf_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         commit_i,
  input  store_entry_t commit_entry_i,
  input  logic         stall_i,
  input  logic         mem_credit_i,
  output logic         commit_ready_o,
  output mem_store_t   mem_req_o,
  output commit_view_t view_o
);

  store_entry_t            mem_q [COMMIT_DEPTH];
  logic [COMMIT_DEPTH-1:0] valid_q;
  logic [COMMIT_DEPTH-1:0] valid_d;
  logic [COMMIT_PTR_W-1:0] rd_ptr_q;
  logic [COMMIT_PTR_W-1:0] wr_ptr_q;
  logic [COMMIT_PTR_W:0]   cnt_q;
  logic [CREDIT_W-1:0]     credit_q;
  logic                    issue;

  // ----------------------------------------------------------------------
  // memory side
  // ----------------------------------------------------------------------

  // there is no grant so a request counts as delivered in the cycle it is sent
  assign issue = (cnt_q != '0) && !stall_i && (credit_q != '0);

  assign mem_req_o.valid = issue;
  assign mem_req_o.store = mem_q[rd_ptr_q];

  // a commit is accepted only when a slot is free at the start of the cycle
  assign commit_ready_o = (cnt_q < COMMIT_DEPTH);

  // an issue and a credit return in the same cycle cancel each other out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CREDIT_W'(MEM_CREDITS);
    end else if (issue && !mem_credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (mem_credit_i && !issue) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // queue state
  // ----------------------------------------------------------------------

  always_comb begin
    valid_d = valid_q;
    if (issue) begin
      valid_d[rd_ptr_q] = 1'b0;
    end
    if (commit_i) begin
      valid_d[wr_ptr_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (commit_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (issue) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (commit_i && !issue) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (issue && !commit_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // committed payload is written at the same edge the speculative head leaves
  always_ff @(posedge clk_i) begin
    if (commit_i) begin
      mem_q[wr_ptr_q] <= commit_entry_i;
    end
  end

  always_comb begin
    view_o.valid = valid_q;
    for (int i = 0; i < COMMIT_DEPTH; i++) begin
      view_o.offset[i] = mem_q[i].addr[OFFSET_MSB:OFFSET_LSB];
    end
  end

  a_commit_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> (cnt_q < COMMIT_DEPTH))
    else $error("commit into a full commit queue");

  // the memory never returns more credits than it holds stores in flight
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_credit_i && !issue |-> (credit_q < MEM_CREDITS))
    else $error("credit count would exceed MEM_CREDITS");

endmodule

/* spec_store_queue.sv */
// ----------------------------------------------------------------------
// speculative store queue
// circular buffer with push, commit pop and flush
// exports the head entry and a view of all valid offsets
// ----------------------------------------------------------------------
module spec_store_queue
  import store_buf_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_i,
  input  store_entry_t store_i,
  input  logic         commit_i,
  input  logic         flush_i,
  output logic         ready_o,
  output store_entry_t commit_entry_o,
  output spec_view_t   view_o
);

  store_entry_t          mem_q [SPEC_DEPTH];
  logic [SPEC_DEPTH-1:0] valid_q;
  logic [SPEC_DEPTH-1:0] valid_d;
  logic [SPEC_PTR_W-1:0] rd_ptr_q;
  logic [SPEC_PTR_W-1:0] wr_ptr_q;
  logic [SPEC_PTR_W:0]   cnt_q;

  // a commit in the same cycle frees the head slot for the new store
  assign ready_o = (cnt_q < SPEC_DEPTH) || commit_i;

  // the commit queue captures the head entry at the commit edge
  assign commit_entry_o = mem_q[rd_ptr_q];

  // the head is cleared before the tail is set because both can be one slot when full
  always_comb begin
    valid_d = valid_q;
    if (commit_i) begin
      valid_d[rd_ptr_q] = 1'b0;
    end
    if (push_i) begin
      valid_d[wr_ptr_q] = 1'b1;
    end
    // a flush drops every speculative store and any store pushed with it
    if (flush_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (flush_i) begin
        // the read pointer stays so the queue restarts where it stood
        wr_ptr_q <= rd_ptr_q;
        cnt_q    <= '0;
      end else begin
        if (push_i) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (commit_i) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        if (push_i && !commit_i) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (commit_i && !push_i) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= store_i;
    end
  end

  // only the word offsets leave the queue for the hazard check
  always_comb begin
    view_o.valid = valid_q;
    for (int i = 0; i < SPEC_DEPTH; i++) begin
      view_o.offset[i] = mem_q[i].addr[OFFSET_MSB:OFFSET_LSB];
    end
  end

  // the core may fill the last slot only while a commit frees the head
  a_spec_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && (cnt_q == SPEC_DEPTH) |-> commit_i)
    else $error("speculative queue pushed while full");

  a_commit_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> (cnt_q != '0))
    else $error("commit from an empty speculative queue");

  // commit and flush come from the same pipeline stage and exclude each other
  a_commit_flush : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !commit_i)
    else $error("commit and flush in the same cycle");

endmodule

/* store_buf_pkg.sv */
// ----------------------------------------------------------------------
// shared definitions of the store buffer
// address, data and page offset widths
// queue depths, pointer widths and the memory credit count
// store entry, queue content views and the memory request
// ----------------------------------------------------------------------
package store_buf_pkg;

  // physical address and store data widths of the load/store unit
  localparam int PADDR_WIDTH = 32;
  localparam int DATA_WIDTH  = 32;
  localparam int BE_WIDTH    = DATA_WIDTH / 8;

  // lookups compare the word index inside a 4 KiB page
  localparam int OFFSET_MSB   = 11;
  localparam int OFFSET_LSB   = 2;
  localparam int OFFSET_WIDTH = OFFSET_MSB - OFFSET_LSB + 1;

  // both depths must be powers of two so that the pointers wrap on their own
  localparam int SPEC_DEPTH   = 4;
  localparam int COMMIT_DEPTH = 4;
  localparam int SPEC_PTR_W   = $clog2(SPEC_DEPTH);
  localparam int COMMIT_PTR_W = $clog2(COMMIT_DEPTH);

  // the memory side allows this many stores in flight after reset
  localparam int MEM_CREDITS = 2;
  localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

  // one buffered store as it travels through both queues
  typedef struct packed {
    logic [PADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]  data;
    logic [BE_WIDTH-1:0]    be;
    logic [1:0]             size;
  } store_entry_t;

  // contents of the speculative queue as seen by the hazard check
  typedef struct packed {
    logic [SPEC_DEPTH-1:0]                   valid;
    logic [SPEC_DEPTH-1:0][OFFSET_WIDTH-1:0] offset;
  } spec_view_t;

  // the same view for the commit queue
  typedef struct packed {
    logic [COMMIT_DEPTH-1:0]                   valid;
    logic [COMMIT_DEPTH-1:0][OFFSET_WIDTH-1:0] offset;
  } commit_view_t;

  // store request towards memory
  typedef struct packed {
    logic         valid;
    store_entry_t store;
  } mem_store_t;

endpackage
